/* src/glue_pkg.sv */
// board glue shared definitions
// bus widths plus the config and read-source bundles

package glue_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int DATA_W = 16; // cpu / custom bus width
	localparam int RTC_W  = 64; // sixteen rtc nibbles

	// --------------------
	// user configuration snapshot from the menu
	// --------------------
	typedef struct packed {
		logic [6:0] memory;  // bit 6 hrtmon, 5:0 ram layout
		logic [3:0] floppy;  // drive count and speed
		logic [4:0] chipset; // 1 ntsc, 2 a1k, 3 ecs, 4 aga
		logic [2:0] ide;     // gayle and drive enables
		logic [3:0] cpu;     // 2 fast chip, 3 fast kick
	} user_cfg_t;            // 23 bits

	// --------------------
	// read sources
	// --------------------
	// cpu side, wired-or onto the cpu read bus
	typedef struct packed {
		logic [DATA_W-1:0] gary;
		logic [DATA_W-1:0] cia;
		logic [DATA_W-1:0] gayle;
		logic [DATA_W-1:0] cart;
	} cpu_src_t;

	// custom chips, wired-or onto the custom bus
	typedef struct packed {
		logic [DATA_W-1:0] agnus;
		logic [DATA_W-1:0] paula;
		logic [DATA_W-1:0] denise;
		logic [DATA_W-1:0] user;
	} custom_src_t;

endpackage

/* src/reset_sequencer.sv */
// reset sequencer
// stretches any reset request over a number of frames and merges
// in the cpu reset lines

`timescale 1ns/1ps

module reset_sequencer #(
	parameter logic [3:0] RESET_FRAMES = 4'd2 // sof pulses to hold reset
) (
	input  logic clk,
	input  logic reset,         // power-on reset
	input  logic clk7_en_i,     // 7 MHz enable
	input  logic sof_i,         // start of frame strobe
	input  logic kbd_rst_i,     // keyboard ctrl-amiga-amiga
	input  logic usr_rst_i,     // reset from menu
	input  logic ext_rst_i,     // external reset source
	input  logic cpu_rst_req_i, // cpu reset request from menu
	input  logic cpu_reset_n_i, // cpu core holding its own reset
	output logic rst_o,         // system reset status
	output logic cpu_reset_n_o  // reset to cpu core
);

	logic       rst_req;   // any request
	logic       sys_reset; // held system reset
	logic [3:0] frame_cnt; // frames seen while held
	logic [3:0] frame_nxt;

	assign rst_req   = kbd_rst_i | usr_rst_i | ext_rst_i;
	assign frame_nxt = frame_cnt + 4'd1;

	// --------------------
	// frame counter and hold
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			sys_reset <= 1'b1;
			frame_cnt <= 4'd0;
		end else if (clk7_en_i) begin
			if (rst_req) begin // restart the hold
				sys_reset <= 1'b1;
				frame_cnt <= 4'd0;
			end else if (sys_reset && sof_i) begin
				frame_cnt <= frame_nxt;
				if (frame_nxt == RESET_FRAMES)
					sys_reset <= 1'b0; // release on the last frame
			end
		end
	end

	// both the cpu core and the sequencer can hold reset
	assign rst_o = sys_reset | ~cpu_reset_n_i;

	assign cpu_reset_n_o = ~(cpu_rst_req_i | sys_reset); // active low

endmodule

/* src/config_regs.sv */
// configuration registers
// registers the menu config, latches pal/ntsc during reset and
// qualifies the turbo modes with the rom overlay

`timescale 1ns/1ps

module config_regs
	import glue_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      clk7_en_i,     // 7 MHz enable
	input  logic      rst_i,         // system reset status
	input  user_cfg_t cfg_i,         // live menu config
	input  logic      ovl_i,         // kickstart overlay active
	input  logic      cpu_custom_i,  // agnus lets the cpu on the bus
	output user_cfg_t cfg_o,         // registered config
	output logic [5:0] memcfg_o,     // ram layout
	output logic [3:0] cpu_config_o,
	output logic      ntsc_o,        // video standard
	output logic      turbokick_o,
	output logic      turbochipram_o
);

	user_cfg_t cfg_q; // snapshot, one cycle behind
	logic      ntsc_q;

	// --------------------
	// snapshot
	// --------------------
	// every clk, no enable
	always_ff @(posedge clk) begin
		cfg_q <= cfg_i;
	end

	assign cfg_o        = cfg_q;
	assign memcfg_o     = cfg_q.memory[5:0];
	assign cpu_config_o = cfg_q.cpu;

	// --------------------
	// video standard
	// --------------------
	// only follows the menu while in reset
	// a change needs a reset to take effect
	always_ff @(posedge clk) begin
		if (reset) begin
			ntsc_q <= 1'b0; // pal
		end else if (clk7_en_i && rst_i) begin
			ntsc_q <= cfg_q.chipset[1];
		end
	end

	assign ntsc_o = ntsc_q;

	// --------------------
	// turbo qualifiers
	// --------------------
	// fast kick needs aga and no overlay
	assign turbokick_o = ~ovl_i
		& cfg_q.cpu[3]
		& cfg_q.chipset[4];

	// fast chip also needs the cpu slot and 2MB chip ram
	assign turbochipram_o = cfg_q.chipset[4]
		& ~ovl_i
		& cfg_q.cpu[2]
		& cpu_custom_i
		& (&cfg_q.memory[1:0]); // chip = 2MB

endmodule

/* src/sync_monitor.sv */
// sync monitor
// frame toggle for the mcu on each falling vsync and
// power led dimming from an hsync clocked counter

`timescale 1ns/1ps

module sync_monitor #(
	parameter int LED_DIV_BITS = 4 // dim counter width
) (
	input  logic clk,
	input  logic reset,
	input  logic clk7_en_i, // 7 MHz enable
	input  logic vsync_i,   // active low vsync
	input  logic hsync_i,   // hsync level
	input  logic led_n_i,   // led off request, from cia port
	input  logic turbo_i,   // cpu in turbo mode
	output logic init_b_o,  // vsync toggle to mcu
	output logic pwrled_o   // power led drive
);

	logic                    vsync_del; // vsync one enable back
	logic                    vsync_t;   // toggle state
	logic [LED_DIV_BITS-1:0] led_cnt;
	logic                    led_dim;

	// --------------------
	// vsync edge toggle
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_del <= 1'b1; // idle high, no edge out of reset
			vsync_t   <= 1'b0;
		end else if (clk7_en_i) begin
			vsync_del <= vsync_i;
			if (~vsync_i && vsync_del)
				vsync_t <= ~vsync_t; // falling edge only
		end
	end

	assign init_b_o = vsync_t;

	// --------------------
	// led dimming
	// --------------------
	// counter runs while hsync is high
	// dim is off one count out of 2**LED_DIV_BITS
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt <= '0;
			led_dim <= 1'b0;
		end else if (hsync_i) begin
			led_cnt <= led_cnt + 1'b1;
			led_dim <= |led_cnt; // previous count value
		end
	end

	// dim in the off state and when turbo is active
	assign pwrled_o = (led_n_i && (led_dim || !turbo_i)) ? 1'b0 : 1'b1;

endmodule

/* src/cpu_read_path.sv */
// cpu read path
// rtc nibble window, wired-or read buses, level 7 interrupt override
// and spi data merge

`timescale 1ns/1ps

module cpu_read_path
	import glue_pkg::*;
(
	input  logic [RTC_W-1:0]  rtc_i,         // sixteen nibbles
	input  logic [5:2]        addr_i,        // cpu address, nibble index
	input  logic              sel_rtc_i,     // rtc space decoded
	input  logic              cpu_rd_i,      // cpu read cycle
	input  cpu_src_t          cpu_src_i,
	input  custom_src_t       custom_src_i,
	input  logic              int7_i,        // level 7 from cart
	input  logic [2:0]        ipl_n_i,       // interrupt lines from paula
	input  logic              paula_sdo_i,
	input  logic              user_sdo_i,
	output logic [DATA_W-1:0] cpu_data_o,    // to the cpu
	output logic [DATA_W-1:0] custom_data_o, // custom bus read data
	output logic [2:0]        cpu_ipl_o,
	output logic              sdo_o          // spi data to host
);

	logic [3:0]        rtc_nib;
	logic [DATA_W-1:0] rtc_word;

	// --------------------
	// rtc window
	// --------------------
	assign rtc_nib  = rtc_i[{addr_i, 2'b00} +: 4]; // index * 4
	assign rtc_word = (sel_rtc_i && cpu_rd_i) ?
		{{(DATA_W-4){1'b0}}, rtc_nib} : '0; // zero when not selected

	// --------------------
	// read buses
	// --------------------
	// idle sources drive zero
	assign cpu_data_o = cpu_src_i.gary
		| cpu_src_i.cia
		| cpu_src_i.gayle
		| cpu_src_i.cart
		| rtc_word;

	assign custom_data_o = custom_src_i.agnus
		| custom_src_i.paula
		| custom_src_i.denise
		| custom_src_i.user;

	// nmi wins over paula
	assign cpu_ipl_o = int7_i ? 3'b000 : ipl_n_i;

	assign sdo_o = paula_sdo_i | user_sdo_i; // inactive slave drives 0

endmodule

/* src/minimig_glue_top.sv */
// board glue top level
// reset sequencing, config registers, sync monitor and cpu read path
// of the home computer board, chip models sit outside

`timescale 1ns/1ps

module minimig_glue_top
	import glue_pkg::*;
#(
	parameter logic [3:0] RESET_FRAMES = 4'd2, // frames of system reset
	parameter int         LED_DIV_BITS = 4     // led dim counter width
) (
	input  logic              clk,
	input  logic              reset,          // power-on reset
	input  logic              clk7_en_i,      // 7 MHz enable

	// reset
	input  logic              sof_i,
	input  logic              kbd_rst_i,
	input  logic              usr_rst_i,
	input  logic              ext_rst_i,
	input  logic              cpu_rst_req_i,
	input  logic              cpu_reset_n_i,
	output logic              rst_o,          // system reset status
	output logic              cpu_reset_n_o,

	// configuration
	input  user_cfg_t         cfg_i,
	input  logic              ovl_i,
	input  logic              cpu_custom_i,
	output user_cfg_t         cfg_o,
	output logic [5:0]        memcfg_o,
	output logic [3:0]        cpu_config_o,
	output logic              ntsc_o,
	output logic              turbokick_o,
	output logic              turbochipram_o,

	// sync and led
	input  logic              vsync_i,
	input  logic              hsync_i,
	input  logic              led_n_i,
	input  logic              turbo_i,
	output logic              init_b_o,
	output logic              pwrled_o,

	// read path
	input  logic [RTC_W-1:0]  rtc_i,
	input  logic [5:2]        addr_i,
	input  logic              sel_rtc_i,
	input  logic              cpu_rd_i,
	input  cpu_src_t          cpu_src_i,
	input  custom_src_t       custom_src_i,
	input  logic              int7_i,
	input  logic [2:0]        ipl_n_i,
	input  logic              paula_sdo_i,
	input  logic              user_sdo_i,
	output logic [DATA_W-1:0] cpu_data_o,
	output logic [DATA_W-1:0] custom_data_o,
	output logic [2:0]        cpu_ipl_o,
	output logic              sdo_o
);

	// --------------------
	// reset
	// --------------------
	reset_sequencer #(
		.RESET_FRAMES (RESET_FRAMES)
	) reset_seq_i (
		.clk           (clk),
		.reset         (reset),
		.clk7_en_i     (clk7_en_i),
		.sof_i         (sof_i),
		.kbd_rst_i     (kbd_rst_i),
		.usr_rst_i     (usr_rst_i),
		.ext_rst_i     (ext_rst_i),
		.cpu_rst_req_i (cpu_rst_req_i),
		.cpu_reset_n_i (cpu_reset_n_i),
		.rst_o         (rst_o),
		.cpu_reset_n_o (cpu_reset_n_o)
	);

	// --------------------
	// config
	// --------------------
	config_regs cfg_regs_i (
		.clk            (clk),
		.reset          (reset),
		.clk7_en_i      (clk7_en_i),
		.rst_i          (rst_o),          // ntsc latch window
		.cfg_i          (cfg_i),
		.ovl_i          (ovl_i),
		.cpu_custom_i   (cpu_custom_i),
		.cfg_o          (cfg_o),
		.memcfg_o       (memcfg_o),
		.cpu_config_o   (cpu_config_o),
		.ntsc_o         (ntsc_o),
		.turbokick_o    (turbokick_o),
		.turbochipram_o (turbochipram_o)
	);

	sync_monitor #(
		.LED_DIV_BITS (LED_DIV_BITS)
	) sync_mon_i (
		.clk       (clk),
		.reset     (reset),
		.clk7_en_i (clk7_en_i),
		.vsync_i   (vsync_i),
		.hsync_i   (hsync_i),
		.led_n_i   (led_n_i),
		.turbo_i   (turbo_i),
		.init_b_o  (init_b_o),
		.pwrled_o  (pwrled_o)
	);

	// combinational, no clock
	cpu_read_path rd_path_i (
		.rtc_i         (rtc_i),
		.addr_i        (addr_i),
		.sel_rtc_i     (sel_rtc_i),
		.cpu_rd_i      (cpu_rd_i),
		.cpu_src_i     (cpu_src_i),
		.custom_src_i  (custom_src_i),
		.int7_i        (int7_i),
		.ipl_n_i       (ipl_n_i),
		.paula_sdo_i   (paula_sdo_i),
		.user_sdo_i    (user_sdo_i),
		.cpu_data_o    (cpu_data_o),
		.custom_data_o (custom_data_o),
		.cpu_ipl_o     (cpu_ipl_o),
		.sdo_o         (sdo_o)
	);

endmodule

/* test/glue_asserts.sv */
// board glue assertions
// bound into the reset sequencer and the sync monitor

`timescale 1ns/1ps

// --------------------
// reset sequencer
// --------------------
module reset_seq_asserts (
	input logic clk,
	input logic reset,
	input logic sof_i,         // start of frame strobe
	input logic hold_i,        // held system reset
	input logic cpu_reset_n_i, // reset to the cpu core
	input logic rst_i          // system reset status
);

	int fails = 0; // failure count

	// without a frame the hold carries on and keeps the cpu in reset
	hold_cpu: assert property (@(posedge clk) hold_i && !sof_i |=> !cpu_reset_n_i)
		else begin
			fails++;
			$error("cpu reset released while the system reset is held");
		end

	after_reset: assert property (@(posedge clk) reset |=> rst_i)
		else begin
			fails++;
			$error("rst_o low on the cycle after reset");
		end

endmodule

// --------------------
// sync monitor
// --------------------
module sync_mon_asserts (
	input logic clk,
	input logic reset,
	input logic clk7_en_i,
	input logic init_b_i // frame toggle
);

	int fails = 0;

	// toggle moves only on an enabled edge
	toggle_on_en: assert property (@(posedge clk) disable iff (reset)
		!$stable(init_b_i) |-> $past(clk7_en_i))
		else begin
			fails++;
			$error("init_b_o changed without clk7_en_i");
		end

endmodule

bind reset_sequencer reset_seq_asserts rs_chk (
	.clk           (clk),
	.reset         (reset),
	.sof_i         (sof_i),
	.hold_i        (sys_reset),
	.cpu_reset_n_i (cpu_reset_n_o),
	.rst_i         (rst_o)
);

bind sync_monitor sync_mon_asserts sm_chk (
	.clk       (clk),
	.reset     (reset),
	.clk7_en_i (clk7_en_i),
	.init_b_i  (init_b_o)
);

/* test/tb_glue.sv */
// board glue testbench
// directed tests for reset sequencing, config registers, ntsc latch,
// cpu read path and sync monitor

`timescale 1ns/1ps

module tb_glue
	import glue_pkg::*;
();

	localparam int MAX_CYCLES = 2000; // the tests need a few hundred cycles

	logic clk, reset, clk7_en_i, sof_i, kbd_rst_i, usr_rst_i, ext_rst_i;
	logic cpu_rst_req_i, cpu_reset_n_i, ovl_i, cpu_custom_i, vsync_i, hsync_i;
	logic led_n_i, turbo_i, sel_rtc_i, cpu_rd_i, int7_i, paula_sdo_i, user_sdo_i;
	logic [RTC_W-1:0] rtc_i;
	logic [5:2] addr_i;
	logic [2:0] ipl_n_i, cpu_ipl_o;
	user_cfg_t cfg_i, cfg_o;
	cpu_src_t cpu_src_i;
	custom_src_t custom_src_i;
	logic rst_o, cpu_reset_n_o, ntsc_o, turbokick_o, turbochipram_o;
	logic init_b_o, pwrled_o, sdo_o;
	logic [5:0] memcfg_o;
	logic [3:0] cpu_config_o;
	logic [DATA_W-1:0] cpu_data_o, custom_data_o;

	int errors = 0;
	int seed = 32'h734c_7833;
	int cycle_cnt = 0;
	logic vs_del_exp = 1'b1; // vsync delay model, idles high
	logic init_exp = 1'b0;   // expected frame toggle

	minimig_glue_top #(.RESET_FRAMES(4'd2), .LED_DIV_BITS(4)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns
	end

	// --------------------
	// watchdog
	// --------------------
	initial begin
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("test failed");
		$finish;
	end

	task automatic check(input string what, input logic [63:0] act, input logic [63:0] exp);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %0h got %0h", $time, what, exp, act);
		end
	endtask

	task automatic next_cycle(); // inputs move 2 ns after the edge
		@(posedge clk);
		#2;
	endtask

	// two sof pulses, the hold lasts through the first
	task automatic frame_release();
		sof_i = 1'b1;
		next_cycle();
		sof_i = 1'b0;
		check("rst_o after first sof", rst_o, 1'b1);
		next_cycle();
		sof_i = 1'b1;
		next_cycle();
		sof_i = 1'b0;
		check("rst_o after second sof", rst_o, 1'b0);
		check("cpu_reset_n_o after release", cpu_reset_n_o, 1'b1);
	endtask

	task automatic reset_sequence();
		check("rst_o out of reset", rst_o, 1'b1);
		check("cpu_reset_n_o out of reset", cpu_reset_n_o, 1'b0);
		frame_release();
		cpu_rst_req_i = 1'b1; // cpu core only
		#1;
		check("cpu_reset_n_o on cpu request", cpu_reset_n_o, 1'b0);
		check("rst_o on cpu request", rst_o, 1'b0);
		cpu_rst_req_i = 1'b0;
		cpu_reset_n_i = 1'b0; // core holds its own reset
		#1;
		check("rst_o with cpu_reset_n_i low", rst_o, 1'b1);
		check("cpu_reset_n_o with cpu_reset_n_i low", cpu_reset_n_o, 1'b1);
		cpu_reset_n_i = 1'b1;
		for (int src = 0; src < 3; src++) begin // ext, kbd, usr
			ext_rst_i = (src == 0);
			kbd_rst_i = (src == 1);
			usr_rst_i = (src == 2);
			next_cycle();
			{ext_rst_i, kbd_rst_i, usr_rst_i} = 3'b000;
			check("rst_o after request", rst_o, 1'b1);
			check("cpu_reset_n_o after request", cpu_reset_n_o, 1'b0);
			frame_release();
		end
	endtask

	task automatic config_snapshot();
		logic [22:0] r;
		user_cfg_t c;
		user_cfg_t prev;
		logic kick, chip;
		prev = cfg_i; // settled for many cycles
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			c = r;
			if (i[0]) begin // open every turbo qualifier
				c.chipset[4] = 1'b1;
				c.cpu[3:2] = 2'b11;
				c.memory[1:0] = 2'b11;
			end
			cfg_i = c;
			#1;
			check("cfg_o before the edge", cfg_o, prev);
			next_cycle();
			check("cfg_o", cfg_o, c);
			check("memcfg_o", memcfg_o, c.memory[5:0]);
			check("cpu_config_o", cpu_config_o, c.cpu);
			for (int m = 0; m < 4; m++) begin
				{ovl_i, cpu_custom_i} = m[1:0];
				#1;
				kick = !ovl_i && c.cpu[3] && c.chipset[4];
				chip = c.chipset[4] && !ovl_i && c.cpu[2] && cpu_custom_i
					&& c.memory[1:0] == 2'b11;
				check("turbokick_o", turbokick_o, kick);
				check("turbochipram_o", turbochipram_o, chip);
			end
			prev = c;
		end
		{ovl_i, cpu_custom_i} = 2'b00;
	endtask

	task automatic ntsc_latch();
		user_cfg_t c;
		c = cfg_i;
		c.chipset[1] = 1'b1;
		cfg_i = c;
		usr_rst_i = 1'b1;
		next_cycle(); // snapshot and hold load together
		usr_rst_i = 1'b0;
		next_cycle();
		check("ntsc_o in reset", ntsc_o, 1'b1);
		c.chipset[1] = 1'b0;
		cfg_i = c;
		repeat (2) next_cycle();
		check("ntsc_o follows in reset", ntsc_o, 1'b0);
		c.chipset[1] = 1'b1;
		cfg_i = c;
		repeat (2) next_cycle();
		check("ntsc_o back in reset", ntsc_o, 1'b1);
		frame_release();
		c.chipset[1] = 1'b0; // outside reset, ignored
		cfg_i = c;
		repeat (4) next_cycle();
		check("ntsc_o held after release", ntsc_o, 1'b1);
	endtask

	task automatic read_path();
		logic [DATA_W-1:0] cpu_exp, cust_exp;
		rtc_i = {$random(seed), $random(seed)};
		for (int n = 0; n < 16; n++) begin // sources idle at zero
			addr_i = n[3:0];
			{sel_rtc_i, cpu_rd_i} = 2'b11;
			#1;
			check("rtc nibble", cpu_data_o, (rtc_i >> (4 * n)) & 64'hf);
			sel_rtc_i = 1'b0;
			#1;
			check("rtc unselected", cpu_data_o, 0);
			{sel_rtc_i, cpu_rd_i} = 2'b10;
			#1;
			check("rtc without read", cpu_data_o, 0);
		end
		for (int k = 0; k < 8; k++) begin
			cpu_src_i = {$random(seed), $random(seed)};
			custom_src_i = {$random(seed), $random(seed)};
			addr_i = $random(seed);
			{sel_rtc_i, cpu_rd_i} = {k[0], 1'b1};
			ipl_n_i = $random(seed);
			int7_i = k[1];
			{paula_sdo_i, user_sdo_i} = k[2:1];
			#1;
			cpu_exp = cpu_src_i.gary | cpu_src_i.cia | cpu_src_i.gayle | cpu_src_i.cart;
			if (k[0])
				cpu_exp |= DATA_W'((rtc_i >> (4 * addr_i)) & 64'hf); // rtc window
			cust_exp = custom_src_i.agnus | custom_src_i.paula
				| custom_src_i.denise | custom_src_i.user;
			check("cpu_data_o", cpu_data_o, cpu_exp);
			check("custom_data_o", custom_data_o, cust_exp);
			check("cpu_ipl_o", cpu_ipl_o, k[1] ? 3'b000 : ipl_n_i);
			check("sdo_o", sdo_o, paula_sdo_i | user_sdo_i);
		end
		{sel_rtc_i, cpu_rd_i, int7_i} = 3'b000;
	endtask

	task automatic vsync_step(input logic v, input logic en);
		vsync_i = v;
		clk7_en_i = en;
		next_cycle();
		if (en) begin
			if (!v && vs_del_exp)
				init_exp = ~init_exp; // falling edge
			vs_del_exp = v;
		end
		check("init_b_o", init_b_o, init_exp);
	endtask

	task automatic sync_and_led();
		logic [3:0] cnt;
		logic dim;
		cnt = '0;
		dim = 1'b0;
		vsync_step(1'b0, 1'b1);
		vsync_step(1'b0, 1'b1);
		vsync_step(1'b1, 1'b1);
		vsync_step(1'b0, 1'b0); // edge waits for the enable
		vsync_step(1'b0, 1'b1);
		vsync_step(1'b1, 1'b1);
		vsync_step(1'b0, 1'b1);
		for (int m = 0; m < 4; m++) begin // no hsync yet
			{led_n_i, turbo_i} = m[1:0];
			#1;
			check("pwrled_o before hsync", pwrled_o, !(led_n_i && (dim || !turbo_i)));
		end
		{led_n_i, turbo_i} = 2'b11; // led shows dim directly
		for (int h = 0; h < 18; h++) begin // past one wrap
			hsync_i = 1'b1;
			next_cycle();
			dim = (cnt != 0);
			cnt = cnt + 1'b1;
			check("pwrled_o while counting", pwrled_o, !dim);
		end
		hsync_i = 1'b0;
		for (int m = 0; m < 4; m++) begin
			{led_n_i, turbo_i} = m[1:0];
			#1;
			check("pwrled_o dimmed", pwrled_o, !(led_n_i && (dim || !turbo_i)));
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		int afails;
		reset = 1'b1;
		clk7_en_i = 1'b1;
		{sof_i, kbd_rst_i, usr_rst_i, ext_rst_i, cpu_rst_req_i} = '0;
		cpu_reset_n_i = 1'b1;
		cfg_i = '0;
		{ovl_i, cpu_custom_i, hsync_i, led_n_i, turbo_i} = '0;
		vsync_i = 1'b1; // vsync idle
		rtc_i = '0;
		addr_i = '0;
		{sel_rtc_i, cpu_rd_i, int7_i, paula_sdo_i, user_sdo_i} = '0;
		ipl_n_i = 3'b111;
		cpu_src_i = '0;
		custom_src_i = '0;
		repeat (3) next_cycle();
		reset = 1'b0;
		reset_sequence();
		config_snapshot();
		ntsc_latch();
		read_path();
		sync_and_led();
		afails = dut_i.reset_seq_i.rs_chk.fails + dut_i.sync_mon_i.sm_chk.fails;
		$display("errors: %0d check, %0d assertion", errors, afails);
		if (errors == 0 && afails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* src.f */
src/glue_pkg.sv
src/reset_sequencer.sv
src/config_regs.sv
src/sync_monitor.sv
src/cpu_read_path.sv
src/minimig_glue_top.sv
test/glue_asserts.sv
test/tb_glue.sv
